/* logic/dcache_pkg.sv */
/* Geometry constants, tag entry, line type and access size and owner
   enums for the direct-mapped data cache */

package dcache_pkg;

  // Core and IO port widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  localparam int IO_W   = 32;

  // Address split into offset 3..0, index 8..4, tag 14..9
  localparam int OFFSET_W = 4;
  localparam int INDEX_W  = 5;
  localparam int TAG_W    = 6;

  localparam int NUM_LINES  = 32;
  localparam int LINE_BYTES = 16;
  localparam int LINE_W     = LINE_BYTES * 8;

  // Set on uncached accesses
  localparam int IO_BIT = 31;

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic             valid;
    logic             dirty;
  } tag_entry_t;

  typedef logic [LINE_W-1:0] line_t;

  // Access size in bytes is 1 << size
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2,
    SIZE_D = 2'd3
  } size_e;

  typedef enum logic [1:0] {
    OWN_NONE = 2'd0,
    OWN_RD   = 2'd1,
    OWN_WR   = 2'd2
  } owner_e;

endpackage

/* logic/dc_arbiter.sv */
/* Read/write arbiter that grants the cache to one requester and holds
   the grant until the access completes */

`timescale 1ns/1ps

module dc_arbiter (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               mem_rd_req,
  input  logic               mem_conflict,
  input  logic               wr_fifo_empty,
  input  logic               wr_fifo_to_be_full,
  input  logic               done,
  output dcache_pkg::owner_e owner
);
  import dcache_pkg::*;

  logic   rd_ok;
  logic   wr_ok;
  owner_e owner_next;

  // A conflicting read must wait for the pipeline to clear
  assign rd_ok = mem_rd_req && !mem_conflict;
  assign wr_ok = !wr_fifo_empty;

  always_comb begin
    owner_next = owner;
    if (owner == OWN_NONE) begin
      // Write wins when the buffer is about to fill or nothing else is ready
      if (wr_ok && (wr_fifo_to_be_full || !rd_ok)) begin
        owner_next = OWN_WR;
      end else if (rd_ok) begin
        owner_next = OWN_RD;
      end
    end else if (done) begin
      owner_next = OWN_NONE;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      owner <= OWN_NONE;
    end else begin
      owner <= owner_next;
    end
  end

  // Granted requester keeps its request up until completion
  a_rd_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    owner == OWN_RD |-> mem_rd_req
  );

  a_wr_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    owner == OWN_WR |-> !wr_fifo_empty
  );

endmodule

/* logic/dc_array.sv */
/* Line-indexed storage array with combinational read, used for both the
   tag store and the data store */

`timescale 1ns/1ps

module dc_array #(
  parameter type entry_t = logic
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [dcache_pkg::INDEX_W-1:0] index,
  input  logic                           wr,
  input  entry_t                         wdata,
  output entry_t                         rdata
);
  import dcache_pkg::*;

  entry_t mem [NUM_LINES];

  // Clearing all entries leaves every tag invalid after reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_LINES; i++) begin
        mem[i] <= '0;
      end
    end else if (wr) begin
      mem[index] <= wdata;
    end
  end

  // Same-cycle lookup for the hit check
  assign rdata = mem[index];

endmodule

/* logic/dc_wr_merge.sv */
/* Line write datapath: selects the fill or stored line as base and
   merges the store bytes into it */

`timescale 1ns/1ps

module dc_wr_merge (
  input  dcache_pkg::line_t               stored_line,
  input  dcache_pkg::line_t               fill_line,
  input  logic                            fill_sel,
  input  logic                            wr_sel,
  input  logic [dcache_pkg::OFFSET_W-1:0] offset,
  input  dcache_pkg::size_e               size,
  input  logic [dcache_pkg::DATA_W-1:0]   wr_data,
  output dcache_pkg::line_t               base_line,
  output dcache_pkg::line_t               new_line
);
  import dcache_pkg::*;

  logic [7:0]            size_mask;
  logic [LINE_BYTES-1:0] byte_en;
  line_t                 shifted;

  assign base_line = fill_sel ? fill_line : stored_line;

  always_comb begin
    case (size)
      SIZE_B:  size_mask = 8'h01;
      SIZE_H:  size_mask = 8'h03;
      SIZE_W:  size_mask = 8'h0f;
      default: size_mask = 8'hff;
    endcase
  end

  // Byte enables and store data moved to the addressed byte lane
  assign byte_en = wr_sel ? ({{(LINE_BYTES-8){1'b0}}, size_mask} << offset) : '0;
  assign shifted = {{(LINE_W-DATA_W){1'b0}}, wr_data} << {offset, 3'b000};

  always_comb begin
    for (int i = 0; i < LINE_BYTES; i++) begin
      if (byte_en[i]) begin
        new_line[i*8 +: 8] = shifted[i*8 +: 8];
      end else begin
        new_line[i*8 +: 8] = base_line[i*8 +: 8];
      end
    end
  end

endmodule

/* logic/dc_rd_align.sv */
/* Load data alignment from a cache line or the IO word, with zero
   extension to the core data width */

`timescale 1ns/1ps

module dc_rd_align (
  input  dcache_pkg::line_t               line,
  input  logic [dcache_pkg::OFFSET_W-1:0] offset,
  input  dcache_pkg::size_e               size,
  input  logic [dcache_pkg::IO_W-1:0]     io_data,
  input  logic                            rd_src_io,
  output logic [dcache_pkg::DATA_W-1:0]   rd_data
);
  import dcache_pkg::*;

  line_t             line_shift;
  logic [IO_W-1:0]   io_shift;
  logic [DATA_W-1:0] raw;
  logic [DATA_W-1:0] size_mask;

  // Addressed byte moved down to lane 0
  assign line_shift = line >> {offset, 3'b000};

  // IO word is aligned, only the low offset bits pick the lane
  assign io_shift = io_data >> {offset[1:0], 3'b000};

  assign raw = rd_src_io ? {{(DATA_W-IO_W){1'b0}}, io_shift} : line_shift[DATA_W-1:0];

  always_comb begin
    case (size)
      SIZE_B:  size_mask = 64'h0000_0000_0000_00ff;
      SIZE_H:  size_mask = 64'h0000_0000_0000_ffff;
      SIZE_W:  size_mask = 64'h0000_0000_ffff_ffff;
      default: size_mask = '1;
    endcase
  end

  // Zero-extend
  assign rd_data = raw & size_mask;

endmodule

/* logic/dc_controller.sv */
/* Hit check and sequencing of hits, line fills with eviction, IO
   accesses, completion pulses and tag updates */

`timescale 1ns/1ps

module dc_controller (
  input  logic                          clk,
  input  logic                          rst_n,
  input  dcache_pkg::owner_e            owner,
  input  logic [dcache_pkg::ADDR_W-1:0] addr,
  input  dcache_pkg::size_e             size,
  input  dcache_pkg::tag_entry_t        stored_tag,
  input  dcache_pkg::line_t             stored_line,
  input  logic                          mem_rd_req,
  input  logic                          wr_fifo_empty,
  input  logic                          dc_miss_ack,
  input  logic                          io_ack,
  output logic                          done,
  output logic                          mem_rd_ready,
  output logic                          mem_wr_done,
  output logic                          mem_rd_busy,
  output logic                          mem_wr_busy,
  output logic                          dc_miss,
  output logic [dcache_pkg::ADDR_W-1:0] dc_miss_addr,
  output logic                          dc_evict,
  output logic [dcache_pkg::ADDR_W-1:0] dc_evict_addr,
  output dcache_pkg::line_t             dc_evict_data,
  output logic                          io_access,
  output logic                          io_rw,
  output logic [dcache_pkg::ADDR_W-1:0] io_addr,
  output logic                          tag_wr,
  output dcache_pkg::tag_entry_t        tag_wdata,
  output logic                          line_wr,
  output logic                          fill_sel,
  output logic                          wr_sel,
  output logic                          rd_src_io
);
  import dcache_pkg::*;

  localparam int TAG_LSB = OFFSET_W + INDEX_W;
  localparam int PAD_W   = ADDR_W - TAG_W - TAG_LSB;

  logic [TAG_W-1:0]   addr_tag;
  logic [INDEX_W-1:0] addr_index;
  logic               active;
  logic               is_wr;
  logic               is_io;
  logic               cache_acc;
  logic               hit;
  logic               fill;
  logic [OFFSET_W:0]  acc_bytes;
  logic [OFFSET_W:0]  acc_end;

  assign addr_tag   = addr[TAG_LSB +: TAG_W];
  assign addr_index = addr[OFFSET_W +: INDEX_W];

  assign active    = owner != OWN_NONE;
  assign is_wr     = owner == OWN_WR;
  assign is_io     = addr[IO_BIT];
  assign cache_acc = active && !is_io;
  assign hit       = stored_tag.valid && (stored_tag.tag == addr_tag);

  // Miss port, held while the owner and its address are held
  assign dc_miss       = cache_acc && !hit;
  assign dc_evict      = dc_miss && stored_tag.valid && stored_tag.dirty;
  assign dc_miss_addr  = {{PAD_W{1'b0}}, addr_tag, addr_index, {OFFSET_W{1'b0}}};
  assign dc_evict_addr = {{PAD_W{1'b0}}, stored_tag.tag, addr_index, {OFFSET_W{1'b0}}};
  assign dc_evict_data = stored_line;
  assign fill          = dc_miss && dc_miss_ack;

  // Uncached port
  assign io_access = active && is_io;
  assign io_rw     = is_wr;
  assign io_addr   = {addr[ADDR_W-1:2], 2'b00};
  assign rd_src_io = is_io;

  assign done         = (cache_acc && (hit || dc_miss_ack)) || (io_access && io_ack);
  assign mem_rd_ready = done && (owner == OWN_RD);
  assign mem_wr_done  = done && is_wr;
  assign mem_rd_busy  = mem_rd_req && !mem_rd_ready;
  assign mem_wr_busy  = !wr_fifo_empty && !mem_wr_done;

  // Line and tag update on write hits and on every fill
  assign fill_sel  = fill;
  assign wr_sel    = cache_acc && is_wr && (hit || dc_miss_ack);
  assign line_wr   = fill || (cache_acc && hit && is_wr);
  assign tag_wr    = line_wr;
  assign tag_wdata = '{tag: addr_tag, valid: 1'b1, dirty: is_wr};

  always_comb begin
    case (size)
      SIZE_B:  acc_bytes = 'd1;
      SIZE_H:  acc_bytes = 'd2;
      SIZE_W:  acc_bytes = 'd4;
      default: acc_bytes = 'd8;
    endcase
  end

  assign acc_end = {1'b0, addr[OFFSET_W-1:0]} + acc_bytes;

  // Two-cycle split accesses are not handled by this cache
  a_no_line_cross: assert property (
    @(posedge clk) disable iff (!rst_n)
    active |-> int'(acc_end) <= LINE_BYTES
  );

  // Miss and IO requests stay up and stable until acknowledged
  a_miss_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    dc_miss && !dc_miss_ack |=> dc_miss && $stable(dc_miss_addr)
  );

  a_io_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    io_access && !io_ack |=> io_access && $stable(io_addr)
  );

endmodule

/* logic/dcache.sv */
/* Data cache top: arbiter, controller, tag and data arrays, store merge
   and load alignment */

`timescale 1ns/1ps

module dcache (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          mem_rd_req,
  input  logic [dcache_pkg::ADDR_W-1:0] mem_rd_addr,
  input  dcache_pkg::size_e             mem_rd_size,
  output logic [dcache_pkg::DATA_W-1:0] mem_rd_data,
  output logic                          mem_rd_ready,
  output logic                          mem_rd_busy,
  input  logic                          wr_fifo_empty,
  input  logic                          wr_fifo_to_be_full,
  input  logic [dcache_pkg::ADDR_W-1:0] mem_wr_addr,
  input  dcache_pkg::size_e             mem_wr_size,
  input  logic [dcache_pkg::DATA_W-1:0] mem_wr_data,
  output logic                          mem_wr_done,
  output logic                          mem_wr_busy,
  input  logic                          mem_conflict,
  output logic                          dc_miss,
  output logic [dcache_pkg::ADDR_W-1:0] dc_miss_addr,
  output logic                          dc_evict,
  output logic [dcache_pkg::ADDR_W-1:0] dc_evict_addr,
  output dcache_pkg::line_t             dc_evict_data,
  input  dcache_pkg::line_t             dc_data_fill,
  input  logic                          dc_miss_ack,
  output logic                          io_access,
  output logic                          io_rw,
  output logic [dcache_pkg::ADDR_W-1:0] io_addr,
  output logic [dcache_pkg::IO_W-1:0]   io_wr_data,
  input  logic [dcache_pkg::IO_W-1:0]   io_rd_data,
  input  logic                          io_ack
);
  import dcache_pkg::*;

  owner_e            owner;
  logic              done;
  logic [ADDR_W-1:0] acc_addr;
  size_e             acc_size;
  tag_entry_t        stored_tag;
  tag_entry_t        tag_wdata;
  logic              tag_wr;
  line_t             stored_line;
  line_t             base_line;
  line_t             new_line;
  logic              line_wr;
  logic              fill_sel;
  logic              wr_sel;
  logic              rd_src_io;

  // Granted request drives the shared lookup
  assign acc_addr   = (owner == OWN_WR) ? mem_wr_addr : mem_rd_addr;
  assign acc_size   = (owner == OWN_WR) ? mem_wr_size : mem_rd_size;
  assign io_wr_data = mem_wr_data[IO_W-1:0];

  dc_arbiter arbiter_i (
    .clk(clk), .rst_n(rst_n), .mem_rd_req(mem_rd_req), .mem_conflict(mem_conflict),
    .wr_fifo_empty(wr_fifo_empty), .wr_fifo_to_be_full(wr_fifo_to_be_full),
    .done(done), .owner(owner)
  );

  dc_array #(.entry_t(tag_entry_t)) tag_store_i (
    .clk(clk), .rst_n(rst_n), .index(acc_addr[OFFSET_W +: INDEX_W]),
    .wr(tag_wr), .wdata(tag_wdata), .rdata(stored_tag)
  );

  dc_array #(.entry_t(line_t)) data_store_i (
    .clk(clk), .rst_n(rst_n), .index(acc_addr[OFFSET_W +: INDEX_W]),
    .wr(line_wr), .wdata(new_line), .rdata(stored_line)
  );

  dc_wr_merge wr_merge_i (
    .stored_line(stored_line), .fill_line(dc_data_fill), .fill_sel(fill_sel),
    .wr_sel(wr_sel), .offset(acc_addr[OFFSET_W-1:0]), .size(acc_size),
    .wr_data(mem_wr_data), .base_line(base_line), .new_line(new_line)
  );

  // Base line carries the fill data in the ack cycle of a read miss
  dc_rd_align rd_align_i (
    .line(base_line), .offset(acc_addr[OFFSET_W-1:0]), .size(acc_size),
    .io_data(io_rd_data), .rd_src_io(rd_src_io), .rd_data(mem_rd_data)
  );

  dc_controller controller_i (
    .clk(clk), .rst_n(rst_n), .owner(owner), .addr(acc_addr), .size(acc_size),
    .stored_tag(stored_tag), .stored_line(stored_line), .mem_rd_req(mem_rd_req),
    .wr_fifo_empty(wr_fifo_empty), .dc_miss_ack(dc_miss_ack), .io_ack(io_ack),
    .done(done), .mem_rd_ready(mem_rd_ready), .mem_wr_done(mem_wr_done),
    .mem_rd_busy(mem_rd_busy), .mem_wr_busy(mem_wr_busy), .dc_miss(dc_miss),
    .dc_miss_addr(dc_miss_addr), .dc_evict(dc_evict), .dc_evict_addr(dc_evict_addr),
    .dc_evict_data(dc_evict_data), .io_access(io_access), .io_rw(io_rw),
    .io_addr(io_addr), .tag_wr(tag_wr), .tag_wdata(tag_wdata), .line_wr(line_wr),
    .fill_sel(fill_sel), .wr_sel(wr_sel), .rd_src_io(rd_src_io)
  );

endmodule

/* include/dcache_tb_table.svh */
/* Stimulus and expected-value table for the data cache testbench,
   included in the testbench module after its package import */

`ifndef DCACHE_TB_TABLE_SVH
`define DCACHE_TB_TABLE_SVH

typedef enum bit {OP_RD, OP_WR} tb_op_e;

// exp_miss and exp_evict tell whether dc_miss and dc_evict are seen at all
typedef struct packed {
  tb_op_e      op;
  logic [31:0] addr;
  size_e       size;
  logic [63:0] wr_data;
  bit          conflict;
  bit          to_be_full;
  bit          exp_miss;
  bit          exp_evict;
  logic [31:0] evict_addr;
  logic [63:0] exp_data;
} tb_entry_t;

localparam int TB_NUM = 21;

// Fill bytes follow the pattern (addr[7:0] * 7 + 3), the IO model echoes its last write
localparam tb_entry_t TB_TABLE [TB_NUM] = '{
  '{OP_RD, 32'h0000_0040, SIZE_D, 64'h0, 0, 0, 1, 0, 32'h0, 64'hF4ED_E6DF_D8D1_CAC3},
  '{OP_RD, 32'h0000_0044, SIZE_W, 64'h0, 0, 0, 0, 0, 32'h0, 64'h0000_0000_F4ED_E6DF},
  '{OP_WR, 32'h0000_0048, SIZE_H, 64'h1234, 0, 0, 0, 0, 32'h0, 64'h0},
  '{OP_RD, 32'h0000_0048, SIZE_W, 64'h0, 0, 0, 0, 0, 32'h0, 64'h0000_0000_1009_1234},
  '{OP_WR, 32'h0000_0041, SIZE_B, 64'hAA, 0, 0, 0, 0, 32'h0, 64'h0},
  '{OP_RD, 32'h0000_0040, SIZE_D, 64'h0, 0, 0, 0, 0, 32'h0, 64'hF4ED_E6DF_D8D1_AAC3},
  '{OP_WR, 32'h0000_004C, SIZE_W, 64'hDEAD_BEEF, 0, 0, 0, 0, 32'h0, 64'h0},
  '{OP_RD, 32'h0000_0048, SIZE_D, 64'h0, 0, 0, 0, 0, 32'h0, 64'hDEAD_BEEF_1009_1234},
  '{OP_WR, 32'h0000_0040, SIZE_D, 64'h0123_4567_89AB_CDEF, 0, 0, 0, 0, 32'h0, 64'h0},
  '{OP_RD, 32'h0000_0046, SIZE_H, 64'h0, 0, 0, 0, 0, 32'h0, 64'h0000_0000_0000_0123},
  '{OP_RD, 32'h0000_0240, SIZE_D, 64'h0, 0, 0, 1, 1, 32'h40, 64'hF4ED_E6DF_D8D1_CAC3},
  '{OP_RD, 32'h0000_0048, SIZE_D, 64'h0, 0, 0, 1, 0, 32'h0, 64'hDEAD_BEEF_1009_1234},
  '{OP_RD, 32'h0000_0040, SIZE_B, 64'h0, 0, 0, 0, 0, 32'h0, 64'h0000_0000_0000_00EF},
  '{OP_WR, 32'h8000_0104, SIZE_W, 64'hCAFE_F00D, 0, 0, 0, 0, 32'h0, 64'h0},
  '{OP_RD, 32'h8000_0104, SIZE_W, 64'h0, 0, 0, 0, 0, 32'h0, 64'h0000_0000_CAFE_F00D},
  '{OP_RD, 32'h0000_0040, SIZE_B, 64'h0, 0, 0, 0, 0, 32'h0, 64'h0000_0000_0000_00EF},
  '{OP_RD, 32'h0000_0044, SIZE_W, 64'h0, 1, 0, 0, 0, 32'h0, 64'h0000_0000_0123_4567},
  '{OP_WR, 32'h0000_004C, SIZE_B, 64'h55, 0, 1, 0, 0, 32'h0, 64'h0},
  '{OP_RD, 32'h0000_004C, SIZE_B, 64'h0, 0, 0, 0, 0, 32'h0, 64'h0000_0000_0000_0055},
  '{OP_WR, 32'h0000_0154, SIZE_W, 64'h1122_3344, 0, 0, 1, 0, 32'h0, 64'h0},
  '{OP_RD, 32'h0000_0150, SIZE_D, 64'h0, 0, 0, 0, 0, 32'h0, 64'h1122_3344_4841_3A33}
};

`endif

/* testbench/dcache_tb.sv */
/* Data cache testbench with clock, reset, memory and IO responders,
   table-driven accesses, checks and timeout */

`timescale 1ns/1ps

module dcache_tb;
  import dcache_pkg::*;

  `include "dcache_tb_table.svh"

  localparam int TIMEOUT_CYCLES = TB_NUM * 40 + 10;
  localparam int MEM_BYTES      = 32768;

  logic              clk;
  logic              rst_n;
  logic              mem_rd_req;
  logic [ADDR_W-1:0] mem_rd_addr;
  size_e             mem_rd_size;
  logic [DATA_W-1:0] mem_rd_data;
  logic              mem_rd_ready;
  logic              mem_rd_busy;
  logic              wr_fifo_empty;
  logic              wr_fifo_to_be_full;
  logic [ADDR_W-1:0] mem_wr_addr;
  size_e             mem_wr_size;
  logic [DATA_W-1:0] mem_wr_data;
  logic              mem_wr_done;
  logic              mem_wr_busy;
  logic              mem_conflict;
  logic              dc_miss;
  logic [ADDR_W-1:0] dc_miss_addr;
  logic              dc_evict;
  logic [ADDR_W-1:0] dc_evict_addr;
  line_t             dc_evict_data;
  line_t             dc_data_fill;
  logic              dc_miss_ack;
  logic              io_access;
  logic              io_rw;
  logic [ADDR_W-1:0] io_addr;
  logic [IO_W-1:0]   io_wr_data;
  logic [IO_W-1:0]   io_rd_data;
  logic              io_ack;

  // Memory side image, updated by evictions
  logic [7:0]  mem_bytes [MEM_BYTES];
  // Expected contents after the core's cached writes
  logic [7:0]  ref_bytes [MEM_BYTES];
  logic [31:0] io_words [256];
  int          ack_delay [64];
  int          delay_idx = 0;
  int          cycle_count = 0;

  dcache dcache_i (.*);

  function automatic logic [7:0] pattern_byte(input int a);
    int v;
    v = (a % 256) * 7 + 3;
    return v[7:0];
  endfunction

  function automatic line_t gather_line(input bit from_ref, input logic [ADDR_W-1:0] addr);
    line_t l;
    int    base;
    base = int'({addr[14:4], 4'h0});
    for (int b = 0; b < LINE_BYTES; b++) begin
      l[b*8 +: 8] = from_ref ? ref_bytes[base + b] : mem_bytes[base + b];
    end
    return l;
  endfunction

  function automatic int next_delay();
    next_delay = ack_delay[delay_idx % 64];
    delay_idx++;
  endfunction

  task automatic check_value(input string name, input logic [LINE_W-1:0] got,
                             input logic [LINE_W-1:0] want);
    if (got !== want) begin
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, want);
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic store_ref(input tb_entry_t e);
    for (int b = 0; b < (1 << int'(e.size)); b++) begin
      ref_bytes[int'(e.addr[14:0]) + b] = e.wr_data[b*8 +: 8];
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) cycle_count <= cycle_count + 1;

  initial begin
    wait (cycle_count > TIMEOUT_CYCLES);
    $display("timeout: the table did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SOME TESTS FAILED");
    $fatal(1, "timeout");
  end

  // Line fill after a random delay, victim stored at the ack
  initial begin
    forever begin
      @(negedge clk);
      if (dc_miss) begin
        repeat (next_delay()) @(posedge clk);
        #1;
        dc_data_fill = gather_line(1'b0, dc_miss_addr);
        if (dc_evict) begin
          for (int b = 0; b < LINE_BYTES; b++) begin
            mem_bytes[int'(dc_evict_addr[14:0]) + b] = dc_evict_data[b*8 +: 8];
          end
        end
        dc_miss_ack = 1'b1;
        @(posedge clk);
        #1;
        dc_miss_ack = 1'b0;
      end
    end
  end

  // IO device with one word per address
  initial begin
    forever begin
      @(negedge clk);
      if (io_access) begin
        repeat (next_delay()) @(posedge clk);
        #1;
        if (io_rw) io_words[io_addr[9:2]] = io_wr_data;
        else io_rd_data = io_words[io_addr[9:2]];
        io_ack = 1'b1;
        @(posedge clk);
        #1;
        io_ack = 1'b0;
      end
    end
  end

  // Runs a read entry, a write entry, or both at once (index -1 when unused)
  task automatic run_access(input int ri, input int wi);
    tb_entry_t         re;
    tb_entry_t         we;
    bit                rd_left;
    bit                wr_left;
    bit                rd_fin;
    bit                wr_fin;
    bit                saw_miss;
    bit                saw_evict;
    int                cyc;
    int                rd_hit_cyc;
    logic [ADDR_W-1:0] cur_addr;
    rd_left = ri >= 0;
    wr_left = wi >= 0;
    re = '0;
    we = '0;
    if (rd_left) re = TB_TABLE[ri];
    if (wr_left) we = TB_TABLE[wi];
    cur_addr = rd_left ? re.addr : we.addr;
    saw_miss = 1'b0;
    saw_evict = 1'b0;
    cyc = 0;
    // Hit completes in the cycle after the request is first sampled
    rd_hit_cyc = 2;
    mem_rd_req = rd_left;
    mem_rd_addr = re.addr;
    mem_rd_size = re.size;
    mem_conflict = re.conflict;
    wr_fifo_empty = !wr_left;
    wr_fifo_to_be_full = we.to_be_full;
    mem_wr_addr = we.addr;
    mem_wr_size = we.size;
    mem_wr_data = we.wr_data;
    if (wr_left && !we.addr[IO_BIT]) store_ref(we);
    // Read held off while the conflict is up
    if (re.conflict) begin
      repeat (4) begin
        @(negedge clk);
        check_value("mem_rd_ready", mem_rd_ready, 1'b0);
        check_value("mem_rd_busy", mem_rd_busy, 1'b1);
      end
      @(posedge clk);
      #1;
      mem_conflict = 1'b0;
    end
    while (rd_left || wr_left) begin
      @(negedge clk);
      cyc++;
      saw_miss |= dc_miss;
      saw_evict |= dc_evict;
      // Expected completion from the acks or from the hit cycle
      wr_fin = wr_left
               && (we.addr[IO_BIT] ? io_ack : (we.exp_miss ? dc_miss_ack : cyc == 2));
      rd_fin = rd_left && !wr_left
               && (re.addr[IO_BIT] ? io_ack : (re.exp_miss ? dc_miss_ack : cyc == rd_hit_cyc));
      if (dc_miss) check_value("dc_miss_addr", dc_miss_addr, {cur_addr[31:4], 4'h0});
      if (dc_evict) begin
        check_value("dc_evict_addr", dc_evict_addr, re.evict_addr | we.evict_addr);
        check_value("dc_evict_data", dc_evict_data, gather_line(1'b1, dc_evict_addr));
      end
      if (io_access) begin
        check_value("io_rw", io_rw, wi >= 0);
        check_value("io_addr", io_addr, {cur_addr[31:2], 2'b00});
        if (io_rw) check_value("io_wr_data", io_wr_data, we.wr_data[31:0]);
      end
      check_value("mem_rd_ready", mem_rd_ready, rd_fin);
      check_value("mem_wr_done", mem_wr_done, wr_fin);
      check_value("mem_rd_busy", mem_rd_busy, rd_left && !rd_fin);
      check_value("mem_wr_busy", mem_wr_busy, wr_left && !wr_fin);
      if (rd_fin) begin
        check_value("mem_rd_data", mem_rd_data, re.exp_data);
        rd_left = 1'b0;
      end
      if (wr_fin) begin
        wr_left = 1'b0;
        // Read is granted once the owner has passed through idle
        rd_hit_cyc = cyc + 2;
      end
      @(posedge clk);
      #1;
      mem_rd_req = rd_left;
      wr_fifo_empty = !wr_left;
    end
    check_value("dc_miss_seen", saw_miss, re.exp_miss | we.exp_miss);
    check_value("dc_evict_seen", saw_evict, re.exp_evict | we.exp_evict);
  endtask

  initial begin
    int i;
    void'($urandom(61));
    for (int d = 0; d < 64; d++) begin
      ack_delay[d] = $urandom_range(4, 1);
    end
    for (int a = 0; a < MEM_BYTES; a++) begin
      mem_bytes[a] = pattern_byte(a);
      ref_bytes[a] = pattern_byte(a);
    end
    for (int w = 0; w < 256; w++) begin
      io_words[w] = {w[7:0], 8'h5a, ~w[7:0], 8'hc3};
    end
    rst_n = 1'b0;
    mem_rd_req = 1'b0;
    mem_rd_addr = '0;
    mem_rd_size = SIZE_B;
    wr_fifo_empty = 1'b1;
    wr_fifo_to_be_full = 1'b0;
    mem_wr_addr = '0;
    mem_wr_size = SIZE_B;
    mem_wr_data = '0;
    mem_conflict = 1'b0;
    dc_data_fill = '0;
    dc_miss_ack = 1'b0;
    io_rd_data = '0;
    io_ack = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("mem_rd_ready", mem_rd_ready, 1'b0);
    check_value("mem_wr_done", mem_wr_done, 1'b0);
    check_value("dc_miss", dc_miss, 1'b0);
    check_value("dc_evict", dc_evict, 1'b0);
    check_value("io_access", io_access, 1'b0);
    check_value("mem_rd_busy", mem_rd_busy, 1'b0);
    check_value("mem_wr_busy", mem_wr_busy, 1'b0);
    @(posedge clk);
    #1;
    i = 0;
    while (i < TB_NUM) begin
      // A nearly full write buffer is paired with the read after it
      if (i + 1 < TB_NUM && TB_TABLE[i].op == OP_WR && TB_TABLE[i].to_be_full
          && TB_TABLE[i + 1].op == OP_RD) begin
        run_access(i + 1, i);
        i += 2;
      end else if (TB_TABLE[i].op == OP_RD) begin
        run_access(i, -1);
        i++;
      end else begin
        run_access(-1, i);
        i++;
      end
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* sources.f */
+incdir+include
logic/dcache_pkg.sv
logic/dc_arbiter.sv
logic/dc_array.sv
logic/dc_wr_merge.sv
logic/dc_rd_align.sv
logic/dc_controller.sv
logic/dcache.sv
testbench/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - files:
      - logic/dcache_pkg.sv
      - logic/dc_arbiter.sv
      - logic/dc_array.sv
      - logic/dc_wr_merge.sv
      - logic/dc_rd_align.sv
      - logic/dc_controller.sv
      - logic/dcache.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/dcache_tb.sv
